// ==== hdl/elink_defines.svh ====
// E-link frame link constants
`ifndef ELINK_DEFINES_SVH
`define ELINK_DEFINES_SVH

// Frame geometry
`define ELINK_FRAME_W   76   // Payload bits per frame
`define ELINK_NBYTES    10   // Payload bytes, top nibble of byte 9 padded
`define ELINK_SYM_W     10   // Encoded 8b10b symbol

// K28 control characters
`define K28_5           8'hBC  // Comma, idle filler
`define K28_1           8'h3C  // Start of frame
`define K28_6           8'hDC  // End of frame

// Receiver lock
`define ELINK_ALIGN_CNT 4    // Commas at one phase before lock

`endif

// ==== hdl/elink_pkg.sv ====
// E-link shared types
`default_nettype none
`include "elink_defines.svh"

package elink_pkg;

  // Byte seen whole or as 8b10b sub-blocks
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [2:0] y;  // 3b/4b part
      logic [4:0] x;  // 5b/6b part
    } xy;
  } elink_byte_u;

  // One character on the line
  typedef struct packed {
    logic        k;   // Control character
    elink_byte_u b;
  } elink_char_t;

  // Frame offered to the sink
  typedef struct packed {
    logic [`ELINK_FRAME_W-1:0] data;
    logic                      bad;  // Code, disparity or length error
  } rx_frame_t;

  // Receiver status, errors sticky until reset
  typedef struct packed {
    logic aligned;
    logic code_err;
    logic disp_err;
    logic overrun;
  } rx_status_t;

endpackage

`default_nettype wire

// ==== hdl/enc_8b10b.sv ====
// 8b10b character encoder
`default_nettype none
`include "elink_defines.svh"

module enc_8b10b import elink_pkg::*; (
  input  elink_char_t             ch,
  input  logic                    rd_in,   // 1 means positive disparity
  output logic [`ELINK_SYM_W-1:0] sym,     // Bit 0 is a, sent first
  output logic                    rd_out
);

  logic [5:0] c6;      // abcdei, a at msb
  logic [3:0] c4;      // fghj, f at msb
  logic [5:0] e6;
  logic [3:0] e4;
  logic       rd_mid;  // Disparity between sub-blocks
  logic       alt7;
  logic       flip4;

  always_comb begin
    case (ch.b.xy.x)  // RD- column of the 5b/6b table
      5'd0:  c6 = 6'b100111;
      5'd1:  c6 = 6'b011101;
      5'd2:  c6 = 6'b101101;
      5'd3:  c6 = 6'b110001;
      5'd4:  c6 = 6'b110101;
      5'd5:  c6 = 6'b101001;
      5'd6:  c6 = 6'b011001;
      5'd7:  c6 = 6'b111000;
      5'd8:  c6 = 6'b111001;
      5'd9:  c6 = 6'b100101;
      5'd10: c6 = 6'b010101;
      5'd11: c6 = 6'b110100;
      5'd12: c6 = 6'b001101;
      5'd13: c6 = 6'b101100;
      5'd14: c6 = 6'b011100;
      5'd15: c6 = 6'b010111;
      5'd16: c6 = 6'b011011;
      5'd17: c6 = 6'b100011;
      5'd18: c6 = 6'b010011;
      5'd19: c6 = 6'b110010;
      5'd20: c6 = 6'b001011;
      5'd21: c6 = 6'b101010;
      5'd22: c6 = 6'b011010;
      5'd23: c6 = 6'b111010;
      5'd24: c6 = 6'b110011;
      5'd25: c6 = 6'b100110;
      5'd26: c6 = 6'b010110;
      5'd27: c6 = 6'b110110;
      5'd28: c6 = 6'b001110;
      5'd29: c6 = 6'b101110;
      5'd30: c6 = 6'b011110;
      default: c6 = 6'b101011;
    endcase
    if (ch.k) c6 = 6'b001111;                 // K28 sub-block
    // Unbalanced codes and D.07 invert under positive disparity
    e6 = (rd_in && ($countones(c6) != 3 || ch.b.xy.x == 5'd7)) ? ~c6 : c6;
    rd_mid = rd_in ^ ($countones(c6) != 3);
    // A7 avoids a run of five inside the symbol
    alt7 = ch.k || (!rd_mid && (ch.b.xy.x == 5'd17 || ch.b.xy.x == 5'd18 ||
                                ch.b.xy.x == 5'd20)) ||
           (rd_mid && (ch.b.xy.x == 5'd11 || ch.b.xy.x == 5'd13 ||
                       ch.b.xy.x == 5'd14));
    case (ch.b.xy.y)
      3'd0: c4 = 4'b1011;
      3'd1: c4 = 4'b1001;
      3'd2: c4 = 4'b0101;
      3'd3: c4 = 4'b1100;
      3'd4: c4 = 4'b1101;
      3'd5: c4 = 4'b1010;
      3'd6: c4 = 4'b0110;
      default: c4 = alt7 ? 4'b0111 : 4'b1110;
    endcase
    // K28 neutral codes flip the other way round
    if (ch.k && $countones(c4) == 2 && ch.b.xy.y != 3'd3)
      flip4 = !rd_mid;
    else
      flip4 = rd_mid && ($countones(c4) != 2 || ch.b.xy.y == 3'd3);
    e4 = flip4 ? ~c4 : c4;
    rd_out = rd_mid ^ ($countones(c4) != 2);
    for (int i = 0; i < 6; i++) sym[i] = e6[5-i];    // a goes to bit 0
    for (int i = 0; i < 4; i++) sym[6+i] = e4[3-i];
    assert (ch.k !== 1'b1 || ch.b.xy.x == 5'd28)
      else $error("enc_8b10b: control flag on non-K28 character");
  end

endmodule

`default_nettype wire

// ==== hdl/dec_8b10b.sv ====
// 8b10b character decoder
`default_nettype none
`include "elink_defines.svh"

module dec_8b10b import elink_pkg::*; (
  input  logic [`ELINK_SYM_W-1:0] sym,
  input  logic                    rd_in,
  output elink_char_t             ch,
  output logic                    code_err,
  output logic                    disp_err,
  output logic                    rd_out
);

  logic [5:0] v6;   // abcdei, a at msb
  logic [3:0] v4;   // fghj as received
  logic [3:0] f4;   // fghj in data polarity
  logic       bad6, bad4;
  logic       rd_mid;
  int         ones6, ones4;

  always_comb begin
    for (int i = 0; i < 6; i++) v6[5-i] = sym[i];
    for (int i = 0; i < 4; i++) v4[3-i] = sym[6+i];
    bad6 = 1'b0;
    ch.k = 1'b0;
    ch.b.xy.x = 5'd0;
    case (v6)  // Both disparity forms
      6'b100111, 6'b011000: ch.b.xy.x = 5'd0;
      6'b011101, 6'b100010: ch.b.xy.x = 5'd1;
      6'b101101, 6'b010010: ch.b.xy.x = 5'd2;
      6'b110001:            ch.b.xy.x = 5'd3;
      6'b110101, 6'b001010: ch.b.xy.x = 5'd4;
      6'b101001:            ch.b.xy.x = 5'd5;
      6'b011001:            ch.b.xy.x = 5'd6;
      6'b111000, 6'b000111: ch.b.xy.x = 5'd7;
      6'b111001, 6'b000110: ch.b.xy.x = 5'd8;
      6'b100101:            ch.b.xy.x = 5'd9;
      6'b010101:            ch.b.xy.x = 5'd10;
      6'b110100:            ch.b.xy.x = 5'd11;
      6'b001101:            ch.b.xy.x = 5'd12;
      6'b101100:            ch.b.xy.x = 5'd13;
      6'b011100:            ch.b.xy.x = 5'd14;
      6'b010111, 6'b101000: ch.b.xy.x = 5'd15;
      6'b011011, 6'b100100: ch.b.xy.x = 5'd16;
      6'b100011:            ch.b.xy.x = 5'd17;
      6'b010011:            ch.b.xy.x = 5'd18;
      6'b110010:            ch.b.xy.x = 5'd19;
      6'b001011:            ch.b.xy.x = 5'd20;
      6'b101010:            ch.b.xy.x = 5'd21;
      6'b011010:            ch.b.xy.x = 5'd22;
      6'b111010, 6'b000101: ch.b.xy.x = 5'd23;
      6'b110011, 6'b001100: ch.b.xy.x = 5'd24;
      6'b100110:            ch.b.xy.x = 5'd25;
      6'b010110:            ch.b.xy.x = 5'd26;
      6'b110110, 6'b001001: ch.b.xy.x = 5'd27;
      6'b001110:            ch.b.xy.x = 5'd28;
      6'b101110, 6'b010001: ch.b.xy.x = 5'd29;
      6'b011110, 6'b100001: ch.b.xy.x = 5'd30;
      6'b101011, 6'b010100: ch.b.xy.x = 5'd31;
      6'b001111, 6'b110000: begin
        ch.b.xy.x = 5'd28;  // K28
        ch.k = 1'b1;
      end
      default: bad6 = 1'b1;
    endcase
    f4 = (v6 == 6'b110000) ? ~v4 : v4;  // K28 after RD+ is inverted
    bad4 = 1'b0;
    ch.b.xy.y = 3'd0;
    case (f4)
      4'b1011, 4'b0100: ch.b.xy.y = 3'd0;
      4'b1001:          ch.b.xy.y = 3'd1;
      4'b0101:          ch.b.xy.y = 3'd2;
      4'b1100, 4'b0011: ch.b.xy.y = 3'd3;
      4'b1101, 4'b0010: ch.b.xy.y = 3'd4;
      4'b1010:          ch.b.xy.y = 3'd5;
      4'b0110:          ch.b.xy.y = 3'd6;
      4'b1110, 4'b0001, 4'b0111, 4'b1000: ch.b.xy.y = 3'd7;  // P7 and A7
      default: bad4 = 1'b1;
    endcase
    ones6 = $countones(v6);
    ones4 = $countones(v4);
    rd_mid = (ones6 == 4) ? 1'b1 : (ones6 == 2) ? 1'b0 : rd_in;
    code_err = bad6 || bad4;
    // Imbalance in the wrong direction, or a neutral code meant for the other side
    disp_err = (ones6 == 4 && rd_in) || (ones6 == 2 && !rd_in) ||
               (v6 == 6'b111000 && rd_in) || (v6 == 6'b000111 && !rd_in) ||
               (ones4 == 3 && rd_mid) || (ones4 == 1 && !rd_mid) ||
               (!ch.k && v4 == 4'b1100 && rd_mid) || (!ch.k && v4 == 4'b0011 && !rd_mid);
    rd_out = (ones4 == 3) ? 1'b1 : (ones4 == 1) ? 1'b0 : rd_mid;  // Follows the code
  end

endmodule

`default_nettype wire

// ==== hdl/elink_tx.sv ====
// E-link frame transmitter
`default_nettype none
`include "elink_defines.svh"

module elink_tx import elink_pkg::*; (
  input  logic                      bitCLK,
  input  logic                      rst,
  input  logic                      tx_req,
  input  logic [`ELINK_FRAME_W-1:0] tx_data,
  output logic                      tx_ack,
  output logic [1:0]                tx_elink2bit
);

  localparam int PayW = `ELINK_NBYTES * 8;

  logic [2:0]              phase;    // 2-bit slice of current symbol
  logic [3:0]              idx;      // Payload byte, NBYTES means end delimiter
  logic                    active;   // Frame on the line
  logic                    start;
  logic [PayW-1:0]         data_q;
  logic [`ELINK_SYM_W-1:0] sym_q, sym_nxt;
  logic                    rd_q, rd_nxt;
  elink_char_t             ch;

  // New frame only at a symbol boundary with the link idle
  assign start = (phase == 3'd4) && !active && tx_req && !tx_ack;

  always_comb begin
    ch.k = 1'b1;
    ch.b.raw = `K28_5;                    // Idle comma
    if (start)
      ch.b.raw = `K28_1;
    else if (active && idx == `ELINK_NBYTES)
      ch.b.raw = `K28_6;
    else if (active) begin
      ch.k = 1'b0;
      ch.b.raw = data_q[idx*8 +: 8];      // Byte 0 first
    end
  end

  enc_8b10b u_enc (
    .ch     (ch),
    .rd_in  (rd_q),
    .sym    (sym_nxt),
    .rd_out (rd_nxt)
  );

  always_ff @(posedge bitCLK) begin
    if (rst) begin
      phase  <= 3'd4;                     // Load a comma straight away
      idx    <= 4'd0;
      active <= 1'b0;
      tx_ack <= 1'b0;
      sym_q  <= '0;
      rd_q   <= 1'b0;                     // Start at RD-
    end else begin
      if (tx_ack && !tx_req) tx_ack <= 1'b0;
      if (phase == 3'd4) begin
        phase <= 3'd0;
        sym_q <= sym_nxt;
        rd_q  <= rd_nxt;
        if (start) begin
          active <= 1'b1;
          tx_ack <= 1'b1;
          idx    <= 4'd0;
        end else if (active) begin
          if (idx == `ELINK_NBYTES) active <= 1'b0;  // Delimiter just loaded
          else idx <= idx + 4'd1;
        end
      end else begin
        phase <= phase + 3'd1;
      end
    end
  end

  always_ff @(posedge bitCLK)
    if (start) data_q <= PayW'(tx_data);  // Zero pad to ten bytes

  assign tx_elink2bit = sym_q[phase*2 +: 2];

  a_data_stable: assert property (@(posedge bitCLK) disable iff (rst)
    tx_req && !tx_ack |=> !(tx_req && !tx_ack) || $stable(tx_data))
    else $error("elink_tx: tx_data changed while tx_req pending");

endmodule

`default_nettype wire

// ==== hdl/elink_rx.sv ====
// E-link frame receiver
`default_nettype none
`include "elink_defines.svh"

module elink_rx import elink_pkg::*; (
  input  logic       bitCLK,
  input  logic       rst,
  input  logic [1:0] rx_elink2bit,
  input  logic       rx_ack,
  output logic       rx_req,
  output rx_frame_t  rx_frame,
  output rx_status_t status
);

  localparam int PayW = `ELINK_NBYTES * 8;
  localparam logic [`ELINK_SYM_W-1:0] CommaN = 10'b0101111100;  // K28.5 RD-
  localparam logic [`ELINK_SYM_W-1:0] CommaP = 10'b1010000011;  // K28.5 RD+

  logic [19:0]      hist;       // Oldest bits at the bottom
  logic [2:0]       ph, dly;
  logic [2:0]       hits;
  logic             found, strobe;
  logic             in_frame, bad_acc;
  logic [3:0]       cnt;        // Data characters seen
  logic [PayW-1:0]  buf_q;
  logic             rd_q, rd_nxt, code_err, disp_err;
  logic             sym_err, is_sop, is_eop, take, done;
  elink_char_t      ch;

  // Comma search over the five even offsets
  always_comb begin
    found = 1'b0;
    dly = 3'd0;
    for (int o = 0; o < 10; o += 2)
      if (hist[o +: 10] == CommaN || hist[o +: 10] == CommaP) begin
        found = 1'b1;
        dly = 3'((10 - o) / 2 % 5);  // Cycles since the comma completed at the top
      end
  end

  assign strobe  = (ph == 3'd4);            // Newest symbol complete in hist[19:10]
  assign sym_err = code_err || disp_err;
  assign is_sop  = ch.k && ch.b.raw == `K28_1 && !sym_err;
  assign is_eop  = ch.k && ch.b.raw == `K28_6 && !sym_err;
  assign done    = strobe && status.aligned && in_frame && is_eop;
  assign take    = strobe && status.aligned && in_frame && !is_sop && !is_eop;

  dec_8b10b u_dec (
    .sym      (hist[19:10]),
    .rd_in    (rd_q),
    .ch       (ch),
    .code_err (code_err),
    .disp_err (disp_err),
    .rd_out   (rd_nxt)
  );

  always_ff @(posedge bitCLK) begin
    if (rst) begin
      ph <= 3'd0;
      hits <= 3'd0;
      rd_q <= 1'b0;
      status <= '0;
      rx_req <= 1'b0;
      in_frame <= 1'b0;
      bad_acc <= 1'b0;
      cnt <= 4'd0;
    end else begin
      if (rx_req && rx_ack) rx_req <= 1'b0;
      if (!strobe) ph <= ph + 3'd1;
      else begin
        rd_q <= rd_nxt;                     // Resyncs from the code itself
        if (!status.aligned) begin
          ph <= found ? dly : 3'd0;         // Slide strobe onto the comma
          if (found && dly == 3'd0) begin
            hits <= hits + 3'd1;
            if (hits == 3'(`ELINK_ALIGN_CNT - 1)) status.aligned <= 1'b1;
          end else hits <= 3'd0;
        end else begin
          ph <= 3'd0;                       // Phase frozen once locked
          if (code_err) status.code_err <= 1'b1;
          if (disp_err) status.disp_err <= 1'b1;
          if (is_sop) begin
            in_frame <= 1'b1;
            cnt <= 4'd0;
            bad_acc <= 1'b0;
          end else if (done) begin
            in_frame <= 1'b0;
            if (rx_req || rx_ack) status.overrun <= 1'b1;  // Sink still busy
            else rx_req <= 1'b1;
          end else if (in_frame) begin
            if (cnt != 4'hf) cnt <= cnt + 4'd1;
            if (sym_err || ch.k) bad_acc <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge bitCLK) begin
    hist <= {rx_elink2bit, hist[19:2]};
    if (take && cnt < `ELINK_NBYTES) buf_q[cnt*8 +: 8] <= ch.b.raw;
    if (done && !rx_req && !rx_ack) begin
      rx_frame.data <= buf_q[`ELINK_FRAME_W-1:0];  // Pad nibble dropped
      rx_frame.bad  <= bad_acc || cnt != `ELINK_NBYTES;
    end
  end

  a_req_hold: assert property (@(posedge bitCLK) disable iff (rst)
    rx_req && !rx_ack |=> rx_req)
    else $error("elink_rx: rx_req dropped without rx_ack");

  a_frame_stable: assert property (@(posedge bitCLK) disable iff (rst)
    rx_req |=> !rx_req || $stable(rx_frame))
    else $error("elink_rx: rx_frame changed while on offer");

endmodule

`default_nettype wire

// ==== hdl/elink_link.sv ====
// E-link transmit and receive top
`default_nettype none
`include "elink_defines.svh"

module elink_link import elink_pkg::*; (
  input  logic                      bitCLK,
  input  logic                      rst,
  input  logic                      tx_req,        // Source side
  input  logic [`ELINK_FRAME_W-1:0] tx_data,
  output logic                      tx_ack,
  output logic [1:0]                tx_elink2bit,  // Serial out
  input  logic [1:0]                rx_elink2bit,  // Serial in
  input  logic                      rx_ack,        // Sink side
  output logic                      rx_req,
  output rx_frame_t                 rx_frame,
  output rx_status_t                status
);

  elink_tx u_tx (
    .bitCLK       (bitCLK),
    .rst          (rst),
    .tx_req       (tx_req),
    .tx_data      (tx_data),
    .tx_ack       (tx_ack),
    .tx_elink2bit (tx_elink2bit)
  );

  elink_rx u_rx (
    .bitCLK       (bitCLK),
    .rst          (rst),
    .rx_elink2bit (rx_elink2bit),
    .rx_ack       (rx_ack),
    .rx_req       (rx_req),
    .rx_frame     (rx_frame),
    .status       (status)
  );

endmodule

`default_nettype wire

// ==== dv/tb_elink_link.sv ====
// E-link loopback testbench
`default_nettype none
`include "elink_defines.svh"

module tb_elink_link import elink_pkg::*;;

  localparam int N         = 12;              // Table entries
  localparam int FRAME_CYC = 12 * 5;          // Twelve symbols of five cycles
  localparam int LIMIT     = N * 200 + 500;   // Cycle budget for the run

  typedef struct packed {
    logic [`ELINK_FRAME_W-1:0] data;
    logic [7:0]                dly;   // Sink ack delay in cycles
    logic                      flip;  // Corrupt one payload bit
    logic                      bad;   // Expected bad flag
  } stim_t;

  logic                      bitCLK;
  logic                      rst;
  logic                      tx_req;
  logic [`ELINK_FRAME_W-1:0] tx_data;
  logic                      tx_ack;
  logic [1:0]                tx_elink2bit;
  logic [1:0]                rx_elink2bit;
  logic [1:0]                flip;          // Line error mask
  logic                      rx_ack;
  logic                      rx_req;
  rx_frame_t                 rx_frame;
  rx_status_t                status;

  stim_t       tbl [N];
  stim_t       exp_q [$];                   // Frames in flight, oldest first
  int unsigned n_mis = 0;
  int unsigned n_fail = 0;
  int unsigned cycles = 0;
  logic        p_req, p_ack, p_rreq, p_rack, p_aligned;
  rx_frame_t   p_frame;

  elink_link DUT (.*);

  assign rx_elink2bit = tx_elink2bit ^ flip;  // Loopback wire

  always #50 bitCLK = ~bitCLK;

  task automatic compare_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
    assert (got === exp)
      else begin
        n_mis++;
        $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      end
  endtask

  task automatic finish_run;
    $display("Errors: %0d mismatches, %0d other failures", n_mis, n_fail);
    if (n_mis + n_fail == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  endtask

  function automatic logic [`ELINK_FRAME_W-1:0] rand_frame();
    return `ELINK_FRAME_W'({$urandom, $urandom, $urandom});
  endfunction

  // Source side of the four-phase handshake
  task automatic send_frame(input stim_t s);
    exp_q.push_back(s);
    tx_data = s.data;
    tx_req = 1'b1;
    do @(negedge bitCLK); while (!tx_ack);  // Start delimiter just loaded
    tx_req = 1'b0;
    if (s.flip) begin
      repeat (15) @(negedge bitCLK);        // Bit a of payload byte 2
      flip = 2'b01;
      @(negedge bitCLK);
      flip = 2'b00;
    end
    while (tx_ack) @(negedge bitCLK);
  endtask

  // Sink side, n frames expected
  task automatic receive_frames(input int n);
    stim_t e;
    logic  skip;
    logic  ovr_exp;
    logic  err_exp;
    skip = 1'b0;
    ovr_exp = 1'b0;
    err_exp = 1'b0;
    for (int i = 0; i < n; i++) begin
      do @(negedge bitCLK); while (!rx_req);
      if (skip) begin
        void'(exp_q.pop_front());           // Lost to the overrun
        skip = 1'b0;
        ovr_exp = 1'b1;
      end
      assert (exp_q.size() > 0)
        else begin
          n_fail++;
          $display("Frame delivered while no frame was expected");
        end
      e = exp_q.pop_front();
      if (e.flip) err_exp = 1'b1;
      compare_value("rx_frame.bad", rx_frame.bad, e.bad);
      if (!e.bad) compare_value("rx_frame.data", rx_frame.data, e.data);
      compare_value("status.overrun", status.overrun, ovr_exp);
      compare_value("status.code_err|disp_err", status.code_err | status.disp_err, err_exp);
      repeat (e.dly) @(negedge bitCLK);
      if (!e.bad) compare_value("rx_frame.data", rx_frame.data, e.data);  // Still on offer
      if (e.dly > FRAME_CYC) skip = 1'b1;   // Next frame completes under back-pressure
      rx_ack = 1'b1;
      while (rx_req) @(negedge bitCLK);
      rx_ack = 1'b0;
    end
  endtask

  // Port protocol monitor, values before the edge
  always @(posedge bitCLK) begin
    if (!rst) begin
      assert (!(p_ack && !tx_ack) || !p_req)
        else begin
          n_fail++;
          $display("tx_ack fell while tx_req was still high");
        end
      assert (!(p_rreq && !rx_req) || p_rack)
        else begin
          n_fail++;
          $display("rx_req fell without rx_ack");
        end
      if (p_rreq && rx_req) compare_value("rx_frame", rx_frame, p_frame);
      assert (!(p_aligned && !status.aligned))
        else begin
          n_fail++;
          $display("Receiver lost alignment");
        end
    end
    p_req = tx_req;
    p_ack = tx_ack;
    p_rreq = rx_req;
    p_rack = rx_ack;
    p_aligned = status.aligned;
    p_frame = rx_frame;
    cycles++;
    if (cycles == LIMIT) begin
      n_fail++;
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      finish_run();
    end
  end

  initial begin
    int n_out;
    bitCLK = 1'b0;
    rst = 1'b1;
    tx_req = 1'b0;
    tx_data = '0;
    rx_ack = 1'b0;
    flip = 2'b00;
    void'($urandom(79));
    tbl[0]  = '{'0, 8'd0, 1'b0, 1'b0};
    tbl[1]  = '{'1, 8'd3, 1'b0, 1'b0};
    tbl[2]  = '{`ELINK_FRAME_W'({10{`K28_5}}), 8'd1, 1'b0, 1'b0};  // Comma bytes as data
    tbl[3]  = '{`ELINK_FRAME_W'({10{`K28_6}}), 8'd0, 1'b0, 1'b0};  // EOF bytes as data
    tbl[4]  = '{rand_frame(), 8'd5, 1'b0, 1'b0};
    tbl[5]  = '{'0, 8'd2, 1'b1, 1'b1};      // Line error in D0.0
    tbl[6]  = '{rand_frame(), 8'd0, 1'b0, 1'b0};
    tbl[7]  = '{rand_frame(), 8'd90, 1'b0, 1'b0};  // Slow sink
    tbl[8]  = '{rand_frame(), 8'd0, 1'b0, 1'b0};   // Overrun victim
    tbl[9]  = '{rand_frame(), 8'd4, 1'b0, 1'b0};
    tbl[10] = '{rand_frame(), 8'd7, 1'b0, 1'b0};
    tbl[11] = '{`ELINK_FRAME_W'({10{`K28_5}}), 8'd0, 1'b0, 1'b0};
    n_out = 0;
    foreach (tbl[i])
      if (tbl[i].dly <= FRAME_CYC) n_out++;
    repeat (3) @(posedge bitCLK);
    @(negedge bitCLK);
    rst = 1'b0;
    compare_value("tx_ack", tx_ack, 1'b0);
    compare_value("rx_req", rx_req, 1'b0);
    compare_value("status", status, 4'h0);
    while (!status.aligned) @(negedge bitCLK);  // Lock on idle commas first
    fork
      begin
        foreach (tbl[i]) send_frame(tbl[i]);
      end
      receive_frames(n_out);
    join
    finish_run();
  end

endmodule

`default_nettype wire

// ==== elink_link.f ====
+incdir+hdl
hdl/elink_pkg.sv
hdl/enc_8b10b.sv
hdl/dec_8b10b.sv
hdl/elink_tx.sv
hdl/elink_rx.sv
hdl/elink_link.sv
dv/tb_elink_link.sv

// ==== Makefile ====
TOP = tb_elink_link

sim:
	verilator --binary --timing --assert -Wno-fatal -f elink_link.f --top-module $(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@! grep -q "TEST RESULT: FAIL" sim.log && grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
